// File: include/ps2_defs.svh
// PS/2 receiver constants: filter depth, frame width, bit count and scan-code prefixes
`ifndef PS2_DEFS_SVH
`define PS2_DEFS_SVH

// Consecutive equal ps2c samples before the filtered level moves
`define PS2_FILTER_DEPTH 8

// Start, eight data bits, parity and stop
`define PS2_FRAME_BITS 11

// Counter load on the start bit, counts the ten remaining bits
`define PS2_BIT_COUNT_INIT 9

// Set-2 prefix bytes
`define PS2_PREFIX_EXT 8'hE0
`define PS2_PREFIX_BREAK 8'hF0

`endif

// File: hw/ps2_pkg.sv
// PS/2 receiver types: frame union and receiver state enum
`include "ps2_defs.svh"

package ps2_pkg;

  // Frame fields, stop bit on top since bits arrive LSB first
  typedef struct packed {
    logic       stop;
    logic       parity;
    logic [7:0] data;
    logic       start;
  } ps2_frame_fields_t;

  // Same 11 bits seen as the shift register or as decoded fields
  typedef union packed {
    logic [`PS2_FRAME_BITS-1:0] raw;
    ps2_frame_fields_t          fields;
  } ps2_frame_t;

  // Receiver control states
  typedef enum logic [1:0] {
    idle = 2'b00,
    dps  = 2'b01,
    load = 2'b10
  } ps2_rx_state_t;

endpackage

// File: hw/ps2_clock_filter.sv
// PS/2 clock debounce filter with falling-edge pulse
`include "ps2_defs.svh"

module ps2_clock_filter (
  input  logic clk,
  input  logic reset,
  input  logic ps2c,
  output logic fall_edge
);

  localparam int DEPTH = `PS2_FILTER_DEPTH;

  logic [DEPTH-1:0] filter_reg;
  logic [DEPTH-1:0] filter_next;
  logic             level_reg;
  logic             level_next;

  // Newest sample enters at the top
  assign filter_next = {ps2c, filter_reg[DEPTH-1:1]};

  // Level only moves once the whole window agrees, otherwise hold
  always_comb begin
    if (&filter_reg) begin
      level_next = 1'b1;
    end else if (~|filter_reg) begin
      level_next = 1'b0;
    end else begin
      level_next = level_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      filter_reg <= '0;
      level_reg  <= 1'b0;
    end else begin
      filter_reg <= filter_next;
      level_reg  <= level_next;
    end
  end

  // High in the cycle before the level drops
  assign fall_edge = level_reg & ~level_next;

endmodule

// File: hw/ps2_frame_shifter.sv
// PS/2 frame shift register fed from the data line
`include "ps2_defs.svh"

module ps2_frame_shifter (
  input  logic               clk,
  input  logic               reset,
  input  logic               ps2d,
  input  logic               shift_en,
  output ps2_pkg::ps2_frame_t frame
);

  localparam int WIDTH = `PS2_FRAME_BITS;

  // Bits arrive LSB first, so each new bit enters at the top and
  // the start bit ends up in bit 0 after a full frame.
  // The value is held between shifts so the checker and the
  // top-level scan_byte stay readable until the next start bit.
  always_ff @(posedge clk) begin
    if (reset) begin
      frame.raw <= '0;
    end else if (shift_en) begin
      frame.raw <= {ps2d, frame.raw[WIDTH-1:1]};
    end
  end

endmodule

// File: hw/ps2_rx_control.sv
// PS/2 receiver control FSM with bit down-counter, shift enable and done tick
`include "ps2_defs.svh"

module ps2_rx_control (
  input  logic clk,
  input  logic reset,
  input  logic rx_en,
  input  logic fall_edge,
  output logic shift_en,
  output logic rx_done_tick
);

  import ps2_pkg::*;

  localparam int CNT_W = $clog2(`PS2_BIT_COUNT_INIT + 1);

  ps2_rx_state_t    state_reg;
  ps2_rx_state_t    state_next;
  logic [CNT_W-1:0] n_reg;
  logic [CNT_W-1:0] n_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= idle;
      n_reg     <= '0;
    end else begin
      state_reg <= state_next;
      n_reg     <= n_next;
    end
  end

  always_comb begin
    state_next   = state_reg;
    n_next       = n_reg;
    shift_en     = 1'b0;
    rx_done_tick = 1'b0;
    case (state_reg)
      idle: begin
        // Start bit only accepted while enabled
        if (fall_edge && rx_en) begin
          shift_en   = 1'b1;
          n_next     = CNT_W'(`PS2_BIT_COUNT_INIT);
          state_next = dps;
        end
      end
      dps: begin
        // Data, parity and stop bits
        if (fall_edge) begin
          shift_en = 1'b1;
          if (n_reg == '0) begin
            state_next = load;
          end else begin
            n_next = n_reg - 1'b1;
          end
        end
      end
      load: begin
        // One extra cycle so the last bit is in the register
        rx_done_tick = 1'b1;
        state_next   = idle;
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

endmodule

// File: hw/ps2_frame_check.sv
// PS/2 frame checker: start, odd parity and stop validation
module ps2_frame_check (
  input  ps2_pkg::ps2_frame_t frame,
  input  logic               rx_done_tick,
  output logic [7:0]         scan_byte,
  output logic               byte_valid,
  output logic               frame_error
);

  logic start_ok;
  logic stop_ok;
  logic parity_ok;
  logic frame_ok;

  // Start low, stop high
  assign start_ok = ~frame.fields.start;
  assign stop_ok  = frame.fields.stop;

  // Odd parity over data and parity bit together
  assign parity_ok = ^{frame.fields.data, frame.fields.parity};

  assign frame_ok = start_ok & stop_ok & parity_ok;

  // Data field is always visible, qualified by byte_valid
  assign scan_byte = frame.fields.data;

  // Exactly one of the two pulses per done tick
  assign byte_valid  = rx_done_tick & frame_ok;
  assign frame_error = rx_done_tick & ~frame_ok;

endmodule

// File: hw/scan_code_decoder.sv
// Set-2 scan-code decoder tracking E0/F0 prefixes and emitting key events
`include "ps2_defs.svh"

module scan_code_decoder (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] scan_byte,
  input  logic       byte_valid,
  input  logic       frame_error,
  output logic       key_valid,
  output logic [7:0] key_code,
  output logic       key_release,
  output logic       key_extended
);

  logic ext_pending;
  logic brk_pending;
  logic is_ext;
  logic is_brk;

  assign is_ext = (scan_byte == `PS2_PREFIX_EXT);
  assign is_brk = (scan_byte == `PS2_PREFIX_BREAK);

  // Prefix flags and the event strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      ext_pending <= 1'b0;
      brk_pending <= 1'b0;
      key_valid   <= 1'b0;
    end else begin
      key_valid <= 1'b0;
      if (frame_error) begin
        // Drop any half-received sequence
        ext_pending <= 1'b0;
        brk_pending <= 1'b0;
      end else if (byte_valid) begin
        if (is_ext) begin
          ext_pending <= 1'b1;
        end else if (is_brk) begin
          brk_pending <= 1'b1;
        end else begin
          key_valid   <= 1'b1;
          ext_pending <= 1'b0;
          brk_pending <= 1'b0;
        end
      end
    end
  end

  // Event payload, only meaningful with key_valid
  always_ff @(posedge clk) begin
    if (byte_valid && !is_ext && !is_brk) begin
      key_code     <= scan_byte;
      key_release  <= brk_pending;
      key_extended <= ext_pending;
    end
  end

endmodule

// File: hw/ps2_keyboard_rx.sv
// PS/2 keyboard receive top: filter, control, shifter, checker and decoder
module ps2_keyboard_rx (
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2c,
  input  logic       ps2d,
  input  logic       rx_en,
  output logic [7:0] scan_byte,
  output logic       byte_valid,
  output logic       frame_error,
  output logic       key_valid,
  output logic [7:0] key_code,
  output logic       key_release,
  output logic       key_extended
);

  import ps2_pkg::*;

  logic       fall_edge;
  logic       shift_en;
  logic       rx_done_tick;
  ps2_frame_t frame;

  // Debounced clock edges
  ps2_clock_filter u_filter (
    .clk       (clk),
    .reset     (reset),
    .ps2c      (ps2c),
    .fall_edge (fall_edge)
  );

  // Bit counting and frame completion
  ps2_rx_control u_control (
    .clk          (clk),
    .reset        (reset),
    .rx_en        (rx_en),
    .fall_edge    (fall_edge),
    .shift_en     (shift_en),
    .rx_done_tick (rx_done_tick)
  );

  ps2_frame_shifter u_shifter (
    .clk      (clk),
    .reset    (reset),
    .ps2d     (ps2d),
    .shift_en (shift_en),
    .frame    (frame)
  );

  // Validation happens in the done cycle
  ps2_frame_check u_check (
    .frame        (frame),
    .rx_done_tick (rx_done_tick),
    .scan_byte    (scan_byte),
    .byte_valid   (byte_valid),
    .frame_error  (frame_error)
  );

  // Key events one cycle after byte_valid
  scan_code_decoder u_decoder (
    .clk          (clk),
    .reset        (reset),
    .scan_byte    (scan_byte),
    .byte_valid   (byte_valid),
    .frame_error  (frame_error),
    .key_valid    (key_valid),
    .key_code     (key_code),
    .key_release  (key_release),
    .key_extended (key_extended)
  );

endmodule

// File: bench/ps2_rx_monitor.sv
// Testbench monitor comparing uut events with the expected outcome and keeping the counts
module ps2_rx_monitor (
  input  logic       clk,
  input  logic [7:0] scan_byte,
  input  logic       byte_valid,
  input  logic       frame_error,
  input  logic       key_valid,
  input  logic [7:0] key_code,
  input  logic       key_release,
  input  logic       key_extended,
  input  logic       start,
  input  logic [1:0] exp_kind,
  input  logic [7:0] exp_byte,
  input  logic       exp_rel,
  input  logic       exp_ext,
  input  int         test_num,
  input  logic       report,
  output logic       check_done,
  output int         pass_count,
  output int         fail_count
);

  localparam int FRAME_TIMEOUT = 2000;
  localparam int KEY_TIMEOUT   = 16;

  // Expected outcome codes
  localparam logic [1:0] KIND_KEY   = 2'd0;
  localparam logic [1:0] KIND_ERROR = 2'd2;
  localparam logic [1:0] KIND_NONE  = 2'd3;

  logic row_ok;

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Error: test %0d %s got 0x%h expected 0x%h", test_num, name, got, exp);
      row_ok = 1'b0;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Test %0d: %s", test_num, what);
    row_ok = 1'b0;
  endtask

  task automatic run_check();
    int   cnt;
    logic seen;
    row_ok     = 1'b1;
    check_done = 1'b0;
    cnt        = 0;
    // Wait for the end of the frame or any other uut event
    while (!(byte_valid || frame_error || key_valid) && cnt < FRAME_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    seen = byte_valid || frame_error || key_valid;
    if (exp_kind == KIND_NONE) begin
      if (seen) begin
        report_failure("receiver produced an event for a frame sent while disabled");
      end
    end else if (!seen) begin
      report_failure("no byte_valid or frame_error before the timeout");
    end else begin
      check_value("byte_valid", 8'(byte_valid), 8'(exp_kind != KIND_ERROR));
      check_value("frame_error", 8'(frame_error), 8'(exp_kind == KIND_ERROR));
      if (exp_kind != KIND_ERROR) begin
        check_value("scan_byte", scan_byte, exp_byte);
      end
      // Key event is due one clock later
      cnt = 0;
      @(negedge clk);
      while (!key_valid && cnt < KEY_TIMEOUT) begin
        @(negedge clk);
        cnt++;
      end
      if (exp_kind == KIND_KEY) begin
        if (!key_valid) begin
          report_failure("no key_valid after byte_valid");
        end else begin
          if (cnt != 0) begin
            report_failure("key_valid did not follow byte_valid by one clock");
          end
          check_value("key_code", key_code, exp_byte);
          check_value("key_release", 8'(key_release), 8'(exp_rel));
          check_value("key_extended", 8'(key_extended), 8'(exp_ext));
        end
      end else if (key_valid) begin
        check_value("key_valid", 8'(key_valid), 8'h00);
      end
    end
    if (row_ok) begin
      pass_count++;
      $display("Test %0d: pass", test_num);
    end else begin
      fail_count++;
      $display("Test %0d: FAIL", test_num);
    end
    check_done = 1'b1;
  endtask

  // Outputs sampled at the falling edge of clk
  initial begin
    check_done = 1'b0;
    pass_count = 0;
    fail_count = 0;
    forever begin
      @(negedge clk);
      if (start) begin
        run_check();
      end else if (report) begin
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
      end
    end
  end

endmodule

// File: bench/ps2_keyboard_rx_tb.sv
// Testbench top for the PS/2 keyboard receiver: clock, reset, stimulus table and frame driver
`include "ps2_defs.svh"

module ps2_keyboard_rx_tb;

  localparam int NUM_FIXED  = 16;
  localparam int NUM_ROWS   = 22;
  localparam int HALF_CLKS  = 20;
  localparam int DONE_LIMIT = 5000;

  localparam logic [1:0] KIND_KEY   = 2'd0;
  localparam logic [1:0] KIND_BYTE  = 2'd1;
  localparam logic [1:0] KIND_ERROR = 2'd2;
  localparam logic [1:0] KIND_NONE  = 2'd3;

  typedef struct packed {
    logic [7:0] data;
    logic       bad_parity;
    logic       enable;
    logic       glitch;
    logic [1:0] kind;
    logic       exp_rel;
    logic       exp_ext;
  } row_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       ps2c;
  logic       ps2d;
  logic       rx_en;
  logic [7:0] scan_byte;
  logic       byte_valid;
  logic       frame_error;
  logic       key_valid;
  logic [7:0] key_code;
  logic       key_release;
  logic       key_extended;

  logic       start;
  logic       report;
  logic [1:0] exp_kind;
  logic [7:0] exp_byte;
  logic       exp_rel;
  logic       exp_ext;
  int         test_num;
  logic       check_done;
  int         pass_count;
  int         fail_count;

  row_t       stim_table [NUM_ROWS];

  always #20 clk = ~clk;

  ps2_keyboard_rx uut (
    .clk          (clk),
    .reset        (reset),
    .ps2c         (ps2c),
    .ps2d         (ps2d),
    .rx_en        (rx_en),
    .scan_byte    (scan_byte),
    .byte_valid   (byte_valid),
    .frame_error  (frame_error),
    .key_valid    (key_valid),
    .key_code     (key_code),
    .key_release  (key_release),
    .key_extended (key_extended)
  );

  ps2_rx_monitor monitor (
    .clk          (clk),
    .scan_byte    (scan_byte),
    .byte_valid   (byte_valid),
    .frame_error  (frame_error),
    .key_valid    (key_valid),
    .key_code     (key_code),
    .key_release  (key_release),
    .key_extended (key_extended),
    .start        (start),
    .exp_kind     (exp_kind),
    .exp_byte     (exp_byte),
    .exp_rel      (exp_rel),
    .exp_ext      (exp_ext),
    .test_num     (test_num),
    .report       (report),
    .check_done   (check_done),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  // Flags are {bad_parity, enable, glitch}, expected flags {release, extended}
  function automatic row_t make_row(input logic [7:0] data, input logic [2:0] flags,
                                    input logic [1:0] kind, input logic [1:0] exp_flags);
    return {data, flags, kind, exp_flags};
  endfunction

  task automatic load_table();
    logic [7:0] data;
    int         i;
    stim_table[0]  = make_row(8'h1C, 3'b010, KIND_KEY, 2'b00);
    stim_table[1]  = make_row(`PS2_PREFIX_BREAK, 3'b010, KIND_BYTE, 2'b00);
    stim_table[2]  = make_row(8'h1C, 3'b010, KIND_KEY, 2'b10);
    stim_table[3]  = make_row(`PS2_PREFIX_EXT, 3'b010, KIND_BYTE, 2'b00);
    stim_table[4]  = make_row(8'h75, 3'b010, KIND_KEY, 2'b01);
    stim_table[5]  = make_row(`PS2_PREFIX_EXT, 3'b010, KIND_BYTE, 2'b00);
    stim_table[6]  = make_row(`PS2_PREFIX_BREAK, 3'b010, KIND_BYTE, 2'b00);
    stim_table[7]  = make_row(8'h75, 3'b010, KIND_KEY, 2'b11);
    // Pending prefix is lost on the bad frame
    stim_table[8]  = make_row(`PS2_PREFIX_EXT, 3'b010, KIND_BYTE, 2'b00);
    stim_table[9]  = make_row(8'h2A, 3'b110, KIND_ERROR, 2'b00);
    stim_table[10] = make_row(8'h1C, 3'b010, KIND_KEY, 2'b00);
    stim_table[11] = make_row(8'h33, 3'b000, KIND_NONE, 2'b00);
    stim_table[12] = make_row(8'h33, 3'b010, KIND_KEY, 2'b00);
    // Short ps2c glitches in every high phase
    stim_table[13] = make_row(8'h4B, 3'b011, KIND_KEY, 2'b00);
    stim_table[14] = make_row(`PS2_PREFIX_BREAK, 3'b011, KIND_BYTE, 2'b00);
    stim_table[15] = make_row(8'h4B, 3'b011, KIND_KEY, 2'b10);
    for (i = NUM_FIXED; i < NUM_ROWS; i++) begin
      data = 8'($urandom);
      if (data == `PS2_PREFIX_EXT || data == `PS2_PREFIX_BREAK) begin
        data = data ^ 8'h01;
      end
      stim_table[i] = make_row(data, 3'b010, KIND_KEY, 2'b00);
    end
  endtask

  // Inputs change 2 time units after the rising edge
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity, input logic glitch);
    logic [10:0] bits;
    int          glitch_len;
    int          i;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (i = 0; i < 11; i++) begin
      ps2d = bits[i];
      if (glitch) begin
        glitch_len = 1 + int'($urandom % (`PS2_FILTER_DEPTH - 2));
        wait_clocks(HALF_CLKS / 2);
        ps2c = 1'b0;
        wait_clocks(glitch_len);
        ps2c = 1'b1;
        wait_clocks(HALF_CLKS - HALF_CLKS / 2 - glitch_len);
      end else begin
        wait_clocks(HALF_CLKS);
      end
      ps2c = 1'b0;
      wait_clocks(HALF_CLKS);
      ps2c = 1'b1;
    end
    wait_clocks(HALF_CLKS);
  endtask

  initial begin
    int r;
    int wait_cnt;
    void'($urandom(14));
    reset    = 1'b1;
    ps2c     = 1'b1;
    ps2d     = 1'b1;
    rx_en    = 1'b0;
    start    = 1'b0;
    report   = 1'b0;
    exp_kind = KIND_NONE;
    exp_byte = 8'h00;
    exp_rel  = 1'b0;
    exp_ext  = 1'b0;
    test_num = 0;
    load_table();
    wait_clocks(8);
    reset = 1'b0;
    for (r = 0; r < NUM_ROWS; r++) begin
      rx_en    = stim_table[r].enable;
      exp_kind = stim_table[r].kind;
      exp_byte = stim_table[r].data;
      exp_rel  = stim_table[r].exp_rel;
      exp_ext  = stim_table[r].exp_ext;
      test_num = r;
      start    = 1'b1;
      wait_clocks(1);
      start = 1'b0;
      send_frame(stim_table[r].data, stim_table[r].bad_parity, stim_table[r].glitch);
      rx_en    = 1'b1;
      wait_cnt = 0;
      while (!check_done && wait_cnt < DONE_LIMIT) begin
        wait_clocks(1);
        wait_cnt++;
      end
      if (!check_done) begin
        $display("Timeout: monitor did not finish test %0d", r);
        $display("Regression failed");
        $finish;
      end
    end
    report = 1'b1;
    wait_clocks(1);
    report = 1'b0;
    wait_clocks(1);
    if (fail_count == 0 && pass_count == NUM_ROWS) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+include
hw/ps2_pkg.sv
hw/ps2_clock_filter.sv
hw/ps2_frame_shifter.sv
hw/ps2_rx_control.sv
hw/ps2_frame_check.sv
hw/scan_code_decoder.sv
hw/ps2_keyboard_rx.sv
bench/ps2_rx_monitor.sv
bench/ps2_keyboard_rx_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = ps2_keyboard_rx_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
